/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vending machine testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module vending_tb \
    -f vending.f --Mdir obj_dir -o vending_sim

output="$(./obj_dir/vending_sim)"
echo "$output"

if echo "$output" | grep -q "^Testbench passed$"; then
    exit 0
else
    exit 1
fi

/* tests/vending_tb.sv */
`timescale 1ns/1ps

module vending_tb import vending_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 3;
    localparam int STEP_TIMEOUT = 40;

    logic         clk = 1'b0;
    logic         rst;
    logic [11:0]  button_sw_oneshot;
    logic [7:0]   display_money_binary;
    stock_t       prod_count_current;
    logic [127:0] line1_text;
    logic [127:0] line2_text;
    logic [6:0]   ddram_address;

    // current step, as read from the data file
    string        test_name;
    logic [11:0]  step_buttons;
    logic [7:0]   exp_money;
    logic [3:0]   exp_count;
    logic [6:0]   exp_addr;
    logic [127:0] exp_line1;
    logic [127:0] exp_line2;

    int tests_run = 0;
    int tests_failed = 0;
    int other_errors = 0;
    int step_errors = 0;

    vending_top #(
        .COIN_SHOW_TICKS (4),
        .REFUND_TICKS    (3),
        .WARN_TICKS      (6)
    ) vending_top_i (
        .clk                  (clk),
        .rst                  (rst),
        .button_sw_oneshot    (button_sw_oneshot),
        .display_money_binary (display_money_binary),
        .prod_count_current   (prod_count_current),
        .line1_text           (line1_text),
        .line2_text           (line2_text),
        .ddram_address        (ddram_address)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // printable view of one lcd line
    function automatic string line_as_text(input lcd_line_t line);
        string text;
        text = "";
        for (int i = 0; i < 16; i++) begin
            if (line.chars[i] >= 8'h20 && line.chars[i] <= 8'h7E) begin
                text = $sformatf("%s%c", text, line.chars[i]);
            end else begin
                text = $sformatf("%s.", text);
            end
        end
        return text;
    endfunction

    // name token from sscanf, leading zero bytes dropped
    function automatic string token_as_text(input logic [255:0] token);
        string text;
        text = "";
        for (int i = 31; i >= 0; i--) begin
            if (token[i*8 +: 8] != 8'h00) begin
                text = $sformatf("%s%c", text, token[i*8 +: 8]);
            end
        end
        return text;
    endfunction

    function automatic logic outputs_match();
        return display_money_binary === exp_money && prod_count_current === exp_count
            && ddram_address === exp_addr && line1_text === exp_line1
            && line2_text === exp_line2;
    endfunction

    task automatic check_value(
        input string        field,
        input logic [127:0] expected,
        input logic [127:0] actual,
        input logic         as_text
    );
        if (actual !== expected) begin
            step_errors++;
            if (as_text) begin
                $display("[FAIL] %0s %0s expected \"%0s\" actual \"%0s\"", test_name, field,
                         line_as_text(expected), line_as_text(actual));
            end else begin
                $display("[FAIL] %0s %0s expected %0h actual %0h", test_name, field,
                         expected, actual);
            end
        end
    endtask

    // one button pulse, then wait for the outputs to reach the expected values
    task automatic apply_step();
        int   cycles;
        logic settled;
        button_sw_oneshot = step_buttons;
        @(posedge clk);
        #1;
        button_sw_oneshot = '0;
        cycles  = 0;
        settled = 1'b0;
        while (!settled && cycles < STEP_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            settled = (cycles >= LATENCY) && outputs_match();
        end
        if (!settled) begin
            $display("%0s: outputs did not settle within %0d cycles", test_name, STEP_TIMEOUT);
        end
        check_value("money", 128'(exp_money), 128'(display_money_binary), 1'b0);
        check_value("count", 128'(exp_count), 128'(prod_count_current), 1'b0);
        check_value("ddram", 128'(exp_addr), 128'(ddram_address), 1'b0);
        check_value("line1", exp_line1, line1_text, 1'b1);
        check_value("line2", exp_line2, line2_text, 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int           fd;
        int           status;
        int           fields;
        string        row;
        logic [255:0] name_token;
        rst               = 1'b0;
        button_sw_oneshot = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;

        fd = $fopen("tests/vending_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/vending_tests.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                row    = "";
                status = $fgets(row, fd);
                // comment lines start with a hash
                if (status != 0 && row.len() > 1 && row.getc(0) != "#") begin
                    fields = $sscanf(row, "%s %h %h %h %h %h %h", name_token, step_buttons,
                                     exp_money, exp_count, exp_addr, exp_line1, exp_line2);
                    if (fields != 7) begin
                        $display("malformed row in test file: %0s", row);
                        other_errors++;
                    end else begin
                        test_name   = token_as_text(name_token);
                        step_errors = 0;
                        apply_step();
                        tests_run++;
                        if (step_errors == 0) begin
                            $display("[PASS] %0s", test_name);
                        end else begin
                            tests_failed++;
                            $display("test %0s ended with %0d errors", test_name, step_errors);
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, passed %0d, failed %0d, other errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, other_errors);
        if (tests_failed == 0 && other_errors == 0 && tests_run > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tests/vending_tests.txt */
# name buttons money count ddram line1 line2
# all fields hex, each lcd line is 16 ascii characters as 32 hex digits
reset_state 000 00 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
down_1 010 00 1 4D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
down_2 010 00 0 4D 322E576174657220313230305720205E 332E4A75696365203135303057205876
down_3 010 00 4 4D 332E4A7569636520313530305720585E 342E4369646572203138303057202076
down_stay 010 00 4 4D 332E4A7569636520313530305720585E 342E4369646572203138303057202076
up_1 400 00 0 0D 332E4A7569636520313530305720585E 342E4369646572203138303057202076
up_2 400 00 1 0D 322E576174657220313230305720205E 332E4A75696365203135303057205876
up_3 400 00 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_10 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_5 002 05 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_1 004 10 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
select_coke 080 10 9 0D 312E436F6B65202031303030572A205E 322E5761746572203132303057202076
buy_coke 200 06 8 0D 5468616E6B20796F7520666F72202020 627579696E6720436F6B652020202020
down_water 010 06 1 4D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
select_water 080 06 1 4D 312E436F6B652020313030305720205E 322E57617465722031323030572A2076
buy_water 200 06 1 4D 4E6F7420656E6F756768206D6F6E6579 666F7220576174657220202020202020
admin_on 800 06 1 4D 596F7520617265206F6E202020202020 61646D696E206D6F6465202020202020
down_juice 010 06 0 4D 322E576174657220313230305720315E 332E4A75696365203135303057203076
restock_juice 020 06 1 4D 322E576174657220313230305720315E 332E4A75696365203135303057203176
up_water 400 06 1 0D 322E576174657220313230305720315E 332E4A75696365203135303057203176
up_coke 400 06 8 0D 312E436F6B652020313030305720385E 322E5761746572203132303057203176
restock_coke 020 06 9 0D 312E436F6B652020313030305720395E 322E5761746572203132303057203176
restock_max 020 06 9 0D 312E436F6B652020313030305720395E 322E5761746572203132303057203176
admin_off 800 06 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
refund 008 00 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_10 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_20 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_30 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_40 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_50 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_60 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_70 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_80 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_sum_90 001 0A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076
coin_refused 001 5A 9 0D 312E436F6B652020313030305720205E 322E5761746572203132303057202076

/* vending.f */
verilog/vending_pkg.sv
verilog/command_decoder.sv
verilog/credit_keeper.sv
verilog/vend_controller.sv
verilog/lcd_composer.sv
verilog/vending_top.sv
tests/vending_tb.sv

/* verilog/command_decoder.sv */
`timescale 1ns/1ps

module command_decoder import vending_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] buttons,
    output cmd_t        cmd,
    output money_t      coin_value
);

    cmd_t   cmd_next;
    money_t coin_next;

    // one command per cycle, highest priority first
    always_comb begin
        cmd_next  = CMD_NONE;
        coin_next = '0;
        if (buttons[BTN_UP]) begin
            cmd_next = CMD_UP;
        end else if (buttons[BTN_DOWN]) begin
            cmd_next = CMD_DOWN;
        end else if (buttons[BTN_SELECT]) begin
            cmd_next = CMD_SELECT;
        end else if (|buttons[BTN_COIN_1:BTN_COIN_10]) begin
            cmd_next = CMD_COIN;
            if (buttons[BTN_COIN_1]) begin
                coin_next = 7'd1;
            end else if (buttons[BTN_COIN_5]) begin
                coin_next = 7'd5;
            end else begin
                coin_next = 7'd10;
            end
        end else if (buttons[BTN_BUY]) begin
            cmd_next = CMD_BUY;
        end else if (buttons[BTN_REFUND]) begin
            cmd_next = CMD_REFUND;
        end else if (buttons[BTN_RESTOCK]) begin
            cmd_next = CMD_RESTOCK;
        end else if (buttons[BTN_ADMIN]) begin
            cmd_next = CMD_ADMIN;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cmd        <= CMD_NONE;
            coin_value <= '0;
        end else begin
            cmd        <= cmd_next;
            coin_value <= coin_next;
        end
    end

endmodule

/* verilog/credit_keeper.sv */
`timescale 1ns/1ps

module credit_keeper import vending_pkg::*; #(
    parameter int unsigned COIN_SHOW_TICKS = vending_pkg::COIN_SHOW_TICKS,
    parameter int unsigned REFUND_TICKS    = vending_pkg::REFUND_TICKS
) (
    input  logic       clk,
    input  logic       rst,
    input  cmd_t       cmd,
    input  money_t     coin_value,
    input  logic       vend,
    input  item_idx_t  vend_item,
    output money_t     balance,
    output logic [7:0] display_money
);

    money_t      coin_shown;
    logic        showing;
    int unsigned show_cnt;
    logic        refunding;
    int unsigned refund_cnt;
    logic [7:0]  coin_sum;
    logic        coin_ok;
    logic        refund_tick;

    assign coin_sum = {1'b0, balance} + {1'b0, coin_value};

    // coins are ignored during a refund countdown
    assign coin_ok = (cmd == CMD_COIN) && !refunding && (coin_sum < {1'b0, MONEY_LIMIT});

    assign refund_tick = refunding && (balance != '0) && (refund_cnt == REFUND_TICKS);

    always_ff @(posedge clk) begin
        if (!rst) begin
            balance       <= '0;
            coin_shown    <= '0;
            showing       <= 1'b0;
            show_cnt      <= 0;
            refunding     <= 1'b0;
            refund_cnt    <= 0;
            display_money <= '0;
        end else begin
            if (coin_ok) begin
                balance <= coin_sum[6:0];
            end else if (vend) begin
                balance <= balance - PRICE[vend_item];
            end else if (refund_tick) begin
                balance <= balance - 7'd1;
            end

            // refund countdown, one unit per period
            if (cmd == CMD_REFUND && !refunding) begin
                refunding  <= 1'b1;
                refund_cnt <= 0;
            end else if (refunding) begin
                if (balance == '0) begin
                    refunding <= 1'b0;
                end else if (refund_cnt == REFUND_TICKS) begin
                    refund_cnt <= 0;
                end else begin
                    refund_cnt <= refund_cnt + 1;
                end
            end

            // coin value hold on the money display
            if (coin_ok) begin
                coin_shown <= coin_value;
                showing    <= 1'b1;
                show_cnt   <= 0;
            end else if (showing) begin
                if (show_cnt == COIN_SHOW_TICKS) begin
                    showing <= 1'b0;
                end else begin
                    show_cnt <= show_cnt + 1;
                end
            end

            display_money <= showing ? {1'b0, coin_shown} : {1'b0, balance};
        end
    end

endmodule

/* verilog/lcd_composer.sv */
`timescale 1ns/1ps

module lcd_composer import vending_pkg::*; #(
    parameter int unsigned WARN_TICKS = vending_pkg::WARN_TICKS
) (
    input  logic         clk,
    input  logic         rst,
    input  item_idx_t    cursor,
    input  logic         cursor_row2,
    input  logic         selected_valid,
    input  item_idx_t    selected_item,
    input  logic         admin,
    input  stock_t       stock [ITEM_COUNT],
    input  logic         warn_start,
    input  warn_t        warn_kind,
    input  item_idx_t    warn_item,
    output logic [127:0] line1_text,
    output logic [127:0] line2_text,
    output logic [6:0]   ddram_address
);

    logic        warn_active;
    int unsigned warn_cnt;
    warn_t       kind_held;
    item_idx_t   item_held;
    warn_t       kind_now;
    item_idx_t   item_now;
    item_idx_t   top_item;
    item_idx_t   bottom_item;
    lcd_line_t   line1_next;
    lcd_line_t   line2_next;
    lcd_line_t   line1;
    lcd_line_t   line2;

    function automatic lcd_line_t product_line(
        input item_idx_t item,
        input logic      marked,
        input stock_t    count,
        input logic      show_count,
        input logic      top_row
    );
        lcd_line_t line;
        line.chars[0]     = CH_ZERO + 8'(item) + 8'd1;
        line.chars[1]     = CH_DOT;
        line.chars[2:6]   = NAME_GLYPHS[item];
        line.chars[7]     = CH_SPACE;
        // price in hundreds, so two digits then "00W"
        line.chars[8]     = CH_ZERO + 8'(PRICE[item] / 7'd10);
        line.chars[9]     = CH_ZERO + 8'(PRICE[item] % 7'd10);
        line.chars[10:12] = {CH_ZERO, CH_ZERO, CH_W};
        line.chars[13]    = marked ? CH_STAR : CH_SPACE;
        if (show_count) begin
            line.chars[14] = CH_ZERO + 8'(count);
        end else if (count == '0) begin
            line.chars[14] = CH_EMPTY;
        end else begin
            line.chars[14] = CH_SPACE;
        end
        line.chars[15]    = top_row ? CH_UP : CH_DOWN;
        return line;
    endfunction

    ////////////////////////////////////////////////////////////
    // scroll window
    ////////////////////////////////////////////////////////////

    always_comb begin
        top_item    = (cursor_row2 && cursor != '0) ? cursor - 2'd1 : cursor;
        bottom_item = top_item + 2'd1;
    end

    ////////////////////////////////////////////////////////////
    // warning hold
    ////////////////////////////////////////////////////////////

    // a new warning shows at once and restarts the hold
    assign kind_now = warn_start ? warn_kind : kind_held;
    assign item_now = warn_start ? warn_item : item_held;

    always_ff @(posedge clk) begin
        if (!rst) begin
            warn_active <= 1'b0;
            warn_cnt    <= 0;
            kind_held   <= WARN_NONE;
            item_held   <= '0;
        end else if (warn_start) begin
            warn_active <= (WARN_TICKS != 0);
            warn_cnt    <= 1;
            kind_held   <= warn_kind;
            item_held   <= warn_item;
        end else if (warn_active) begin
            if (warn_cnt >= WARN_TICKS) begin
                warn_active <= 1'b0;
            end else begin
                warn_cnt <= warn_cnt + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // line text
    ////////////////////////////////////////////////////////////

    always_comb begin
        line1_next = product_line(top_item, selected_valid && selected_item == top_item,
                                  stock[top_item], admin, 1'b1);
        line2_next = product_line(bottom_item, selected_valid && selected_item == bottom_item,
                                  stock[bottom_item], admin, 1'b0);
        if (warn_start || warn_active) begin
            case (kind_now)
                WARN_NO_MONEY: begin
                    line1_next.flat = TXT_NO_MONEY;
                    line2_next.flat = {TXT_FOR, NAME_GLYPHS[item_now], {7{CH_SPACE}}};
                end
                WARN_BOUGHT: begin
                    line1_next.flat = TXT_THANKS;
                    line2_next.flat = {TXT_BUYING, NAME_GLYPHS[item_now], {4{CH_SPACE}}};
                end
                WARN_ADMIN: begin
                    line1_next.flat = TXT_ON;
                    line2_next.flat = TXT_ADMIN;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        line1         <= line1_next;
        line2         <= line2_next;
        ddram_address <= (cursor == top_item) ? ADDR_ROW1 : ADDR_ROW2;
    end

    assign line1_text = line1.flat;
    assign line2_text = line2.flat;

endmodule

/* verilog/vend_controller.sv */
`timescale 1ns/1ps

module vend_controller import vending_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cmd_t      cmd,
    input  money_t    balance,
    output logic      vend,
    output item_idx_t vend_item,
    output item_idx_t cursor,
    output logic      cursor_row2,
    output logic      selected_valid,
    output item_idx_t selected_item,
    output logic      admin,
    output stock_t    stock [ITEM_COUNT],
    output stock_t    prod_count_current,
    output logic      warn_start,
    output warn_t     warn_kind,
    output item_idx_t warn_item
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            vend               <= 1'b0;
            vend_item          <= '0;
            cursor             <= '0;
            cursor_row2        <= 1'b0;
            selected_valid     <= 1'b0;
            selected_item      <= '0;
            admin              <= 1'b0;
            stock              <= STOCK_INIT;
            prod_count_current <= STOCK_INIT[0];
            warn_start         <= 1'b0;
            warn_kind          <= WARN_NONE;
            warn_item          <= '0;
        end else begin
            // pulses last one cycle
            vend       <= 1'b0;
            warn_start <= 1'b0;

            case (cmd)
                CMD_UP: begin
                    if (cursor != '0) begin
                        cursor <= cursor - 2'd1;
                    end
                    cursor_row2 <= 1'b0;
                end
                CMD_DOWN: begin
                    if (cursor != item_idx_t'(ITEM_COUNT - 1)) begin
                        cursor <= cursor + 2'd1;
                    end
                    cursor_row2 <= 1'b1;
                end
                CMD_SELECT: begin
                    // second select on the same product drops it
                    if (selected_valid && selected_item == cursor) begin
                        selected_valid <= 1'b0;
                    end else if (stock[cursor] != '0) begin
                        selected_valid <= 1'b1;
                        selected_item  <= cursor;
                    end
                end
                CMD_BUY: begin
                    if (selected_valid) begin
                        warn_start     <= 1'b1;
                        warn_item      <= selected_item;
                        selected_valid <= 1'b0;
                        if (balance >= PRICE[selected_item]) begin
                            vend                 <= 1'b1;
                            vend_item            <= selected_item;
                            stock[selected_item] <= stock[selected_item] - 4'd1;
                            warn_kind            <= WARN_BOUGHT;
                        end else begin
                            warn_kind <= WARN_NO_MONEY;
                        end
                    end
                end
                CMD_RESTOCK: begin
                    if (admin && stock[cursor] < STOCK_MAX) begin
                        stock[cursor] <= stock[cursor] + 4'd1;
                    end
                end
                CMD_ADMIN: begin
                    admin <= !admin;
                    // screen only on entry
                    if (!admin) begin
                        warn_start <= 1'b1;
                        warn_kind  <= WARN_ADMIN;
                    end
                end
                default: begin
                end
            endcase

            prod_count_current <= stock[cursor];
        end
    end

endmodule

/* verilog/vending_pkg.sv */
package vending_pkg;

    ////////////////////////////////////////////////////////////
    // products, stock and money
    ////////////////////////////////////////////////////////////

    localparam int ITEM_COUNT = 4;
    typedef logic [1:0] item_idx_t;

    // credit in units of 100 won
    typedef logic [6:0] money_t;
    localparam money_t MONEY_LIMIT = 7'd100;

    typedef logic [3:0] stock_t;
    localparam stock_t STOCK_MAX = 4'd9;
    localparam stock_t STOCK_INIT [ITEM_COUNT] = '{4'd9, 4'd1, 4'd0, 4'd4};

    localparam money_t PRICE [ITEM_COUNT] = '{7'd10, 7'd12, 7'd15, 7'd18};

    // first glyph of a name sits in element 0
    localparam logic [0:4][7:0] NAME_GLYPHS [ITEM_COUNT] = '{
        "Coke ", "Water", "Juice", "Cider"
    };

    // default hold times in clock cycles
    localparam int unsigned COIN_SHOW_TICKS = 2000000;
    localparam int unsigned REFUND_TICKS    = 1000000;
    localparam int unsigned WARN_TICKS      = 2000000;

    ////////////////////////////////////////////////////////////
    // button word and commands
    ////////////////////////////////////////////////////////////

    localparam int BTN_ADMIN   = 11;
    localparam int BTN_UP      = 10;
    localparam int BTN_BUY     = 9;
    localparam int BTN_SELECT  = 7;
    localparam int BTN_RESTOCK = 5;
    localparam int BTN_DOWN    = 4;
    localparam int BTN_REFUND  = 3;
    localparam int BTN_COIN_1  = 2;
    localparam int BTN_COIN_5  = 1;
    localparam int BTN_COIN_10 = 0;

    typedef enum logic [3:0] {
        CMD_NONE,
        CMD_UP,
        CMD_DOWN,
        CMD_SELECT,
        CMD_COIN,
        CMD_BUY,
        CMD_REFUND,
        CMD_RESTOCK,
        CMD_ADMIN
    } cmd_t;

    typedef enum logic [1:0] {
        WARN_NONE,
        WARN_NO_MONEY,
        WARN_BOUGHT,
        WARN_ADMIN
    } warn_t;

    ////////////////////////////////////////////////////////////
    // character LCD
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] ADDR_ROW1 = 7'h0D;
    localparam logic [6:0] ADDR_ROW2 = 7'h4D;

    localparam logic [7:0] CH_ZERO  = 8'h30;
    localparam logic [7:0] CH_SPACE = 8'h20;
    localparam logic [7:0] CH_DOT   = 8'h2E;
    localparam logic [7:0] CH_STAR  = 8'h2A;
    localparam logic [7:0] CH_EMPTY = 8'h58;
    localparam logic [7:0] CH_UP    = 8'h5E;
    localparam logic [7:0] CH_DOWN  = 8'h76;
    localparam logic [7:0] CH_W     = 8'h57;

    localparam logic [127:0] TXT_NO_MONEY = "Not enough money";
    localparam logic [127:0] TXT_THANKS   = "Thank you for   ";
    localparam logic [127:0] TXT_ON       = "You are on      ";
    localparam logic [127:0] TXT_ADMIN    = "admin mode      ";
    localparam logic [31:0]  TXT_FOR      = "for ";
    localparam logic [55:0]  TXT_BUYING   = "buying ";

    // one display line, flat at the ports, per character when composed
    typedef union packed {
        logic [127:0]      flat;
        logic [0:15][7:0]  chars;
    } lcd_line_t;

endpackage

/* verilog/vending_top.sv */
`timescale 1ns/1ps

module vending_top import vending_pkg::*; #(
    parameter int unsigned COIN_SHOW_TICKS = vending_pkg::COIN_SHOW_TICKS,
    parameter int unsigned REFUND_TICKS    = vending_pkg::REFUND_TICKS,
    parameter int unsigned WARN_TICKS      = vending_pkg::WARN_TICKS
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [11:0]  button_sw_oneshot,
    output logic [7:0]   display_money_binary,
    output stock_t       prod_count_current,
    output logic [127:0] line1_text,
    output logic [127:0] line2_text,
    output logic [6:0]   ddram_address
);

    cmd_t      cmd;
    money_t    coin_value;
    money_t    balance;
    logic      vend;
    item_idx_t vend_item;
    item_idx_t cursor;
    logic      cursor_row2;
    logic      selected_valid;
    item_idx_t selected_item;
    logic      admin;
    stock_t    stock [ITEM_COUNT];
    logic      warn_start;
    warn_t     warn_kind;
    item_idx_t warn_item;

    // input side
    command_decoder command_decoder_i (
        .clk        (clk),
        .rst        (rst),
        .buttons    (button_sw_oneshot),
        .cmd        (cmd),
        .coin_value (coin_value)
    );

    // processing
    credit_keeper #(
        .COIN_SHOW_TICKS (COIN_SHOW_TICKS),
        .REFUND_TICKS    (REFUND_TICKS)
    ) credit_keeper_i (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .coin_value    (coin_value),
        .vend          (vend),
        .vend_item     (vend_item),
        .balance       (balance),
        .display_money (display_money_binary)
    );

    vend_controller vend_controller_i (
        .clk                (clk),
        .rst                (rst),
        .cmd                (cmd),
        .balance            (balance),
        .vend               (vend),
        .vend_item          (vend_item),
        .cursor             (cursor),
        .cursor_row2        (cursor_row2),
        .selected_valid     (selected_valid),
        .selected_item      (selected_item),
        .admin              (admin),
        .stock              (stock),
        .prod_count_current (prod_count_current),
        .warn_start         (warn_start),
        .warn_kind          (warn_kind),
        .warn_item          (warn_item)
    );

    // output side
    lcd_composer #(
        .WARN_TICKS (WARN_TICKS)
    ) lcd_composer_i (
        .clk            (clk),
        .rst            (rst),
        .cursor         (cursor),
        .cursor_row2    (cursor_row2),
        .selected_valid (selected_valid),
        .selected_item  (selected_item),
        .admin          (admin),
        .stock          (stock),
        .warn_start     (warn_start),
        .warn_kind      (warn_kind),
        .warn_item      (warn_item),
        .line1_text     (line1_text),
        .line2_text     (line2_text),
        .ddram_address  (ddram_address)
    );

endmodule
